// ==== design/noc_pkg.sv ====
/*
  noc_pkg
  Shared port encoding and sizing for the five-port mesh router
  switch allocator. The port code serves as next-hop direction,
  crossbar select and arbiter identity.
*/
package noc_pkg;

  // width of a port code
  localparam int PORT_CODE_W = 3;

  // north, south, west, east, local
  localparam int NUM_PORTS = 5;

  // inputs competing for one output, all but the output itself
  localparam int CAND_N = NUM_PORTS - 1;

  // direction codes, also the bit index into grant vectors
  typedef enum logic [PORT_CODE_W-1:0] {
    PORT_N = 3'd0,
    PORT_S = 3'd1,
    PORT_W = 3'd2,
    PORT_E = 3'd3,
    PORT_L = 3'd4
  } port_e;

endpackage : noc_pkg

// ==== design/rr_priority_ring.sv ====
/*
  rr_priority_ring
  Round-robin pointer for one output port. The pointer names the
  candidate with top priority. After a grant it moves to the
  candidate following the winner, so the winner drops to last place.
*/
`timescale 1ns/1ps

module rr_priority_ring (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       advance_i,
  input  logic [1:0] winner_idx_i,
  output logic [1:0] ptr_o
);

  import noc_pkg::*;

  logic [1:0] ptr_q;
  logic [1:0] ptr_next;

  // winner + 1, wrapping at the candidate count
  always_comb begin
    if (winner_idx_i == 2'(CAND_N - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = winner_idx_i + 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (advance_i) begin
      ptr_q <= ptr_next;
    end
  end

  assign ptr_o = ptr_q;

  // the selector must hand over a clean index whenever a grant fires
  a_winner_known : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    advance_i |-> !$isunknown(winner_idx_i)
  ) else $error("rr_priority_ring: unknown winner index on advance");

endmodule : rr_priority_ring

// ==== design/priority_select.sv ====
/*
  priority_select
  Combinational circular search over the candidate desire bits.
  Starting at the ring pointer it finds the first desiring candidate
  and returns its index, or drops found when nobody asks.
*/
`timescale 1ns/1ps

module priority_select (
  input  logic [noc_pkg::CAND_N-1:0] desire_i,
  input  logic [1:0]                 ptr_i,
  output logic                       found_o,
  output logic [1:0]                 winner_idx_o
);

  import noc_pkg::*;

  logic [1:0] idx;
  logic [1:0] hit_idx;
  logic       hit;

  // walk from the farthest position back to the pointer, so the
  // candidate nearest the pointer is the last one to overwrite
  always_comb begin
    hit     = 1'b0;
    hit_idx = ptr_i;
    idx     = ptr_i;
    for (int k = CAND_N - 1; k >= 0; k--) begin
      // two-bit add wraps modulo the candidate count
      idx = ptr_i + 2'(k);
      if (desire_i[idx]) begin
        hit     = 1'b1;
        hit_idx = idx;
      end
    end
  end

  assign found_o      = hit;
  assign winner_idx_o = hit ? hit_idx : 2'd0;

endmodule : priority_select

// ==== design/credit_counter.sv ====
/*
  credit_counter
  Free-slot counter for the buffer behind one output port. Starts
  full, loses a slot on every grant, regains one on every return
  strobe. Credit is available while the count is nonzero.
*/
`timescale 1ns/1ps

module credit_counter #(
  parameter int BUF_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic consume_i,
  input  logic return_i,
  output logic credit_ok_o
);

  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= CNT_W'(BUF_DEPTH);
    end else begin
      // consume and return together cancel out
      case ({consume_i, return_i})
        2'b10:   count_q <= count_q - 1'b1;
        2'b01:   count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign credit_ok_o = (count_q != '0);

  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    consume_i |-> count_q != '0
  ) else $error("credit_counter: grant issued with no credit");

  // a return with every slot free means the downstream side miscounted
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    return_i |-> count_q != CNT_W'(BUF_DEPTH)
  ) else $error("credit_counter: credit returned beyond buffer depth");

endmodule : credit_counter

// ==== design/port_arbiter.sv ====
/*
  port_arbiter
  Round-robin arbiter for one output port. Decodes which of the four
  other inputs want this output, picks one through the rotating ring,
  gates the pick with downstream credit and registers the grant one-hot,
  the crossbar select and a valid flag.
*/
`timescale 1ns/1ps

module port_arbiter #(
  parameter noc_pkg::port_e OUT_PORT = noc_pkg::PORT_L
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [noc_pkg::NUM_PORTS-1:0] req_i,
  input  noc_pkg::port_e                n_dest_i,
  input  noc_pkg::port_e                s_dest_i,
  input  noc_pkg::port_e                w_dest_i,
  input  noc_pkg::port_e                e_dest_i,
  input  noc_pkg::port_e                l_dest_i,
  input  logic                          credit_ok_i,
  output logic                          fire_o,
  output logic [noc_pkg::NUM_PORTS-1:0] grant_o,
  output noc_pkg::port_e                sel_o,
  output logic                          valid_o
);

  import noc_pkg::*;

  port_e                 dest      [NUM_PORTS];
  port_e                 cand_port [CAND_N];
  logic [CAND_N-1:0]     desire;
  logic [1:0]            ptr;
  logic                  found;
  logic [1:0]            winner_idx;
  logic                  fire;
  port_e                 win_port;
  logic [NUM_PORTS-1:0]  grant_d;
  logic [NUM_PORTS-1:0]  grant_q;
  port_e                 sel_q;
  logic                  valid_q;

  assign dest[PORT_N] = n_dest_i;
  assign dest[PORT_S] = s_dest_i;
  assign dest[PORT_W] = w_dest_i;
  assign dest[PORT_E] = e_dest_i;
  assign dest[PORT_L] = l_dest_i;

  // candidates are N, S, W, E, L in order with this output skipped,
  // which also keeps a U-turn request out of the race
  for (genvar c = 0; c < CAND_N; c++) begin : g_cand
    localparam port_e CAND = port_e'((c < int'(OUT_PORT)) ? c : c + 1);
    assign cand_port[c] = CAND;
    assign desire[c]    = req_i[CAND] && (dest[CAND] == OUT_PORT);
  end

  rr_priority_ring u_ring (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .advance_i    (fire),
    .winner_idx_i (winner_idx),
    .ptr_o        (ptr)
  );

  priority_select u_select (
    .desire_i     (desire),
    .ptr_i        (ptr),
    .found_o      (found),
    .winner_idx_o (winner_idx)
  );

  assign fire     = found && credit_ok_i;
  assign win_port = cand_port[winner_idx];

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      grant_d[p] = fire && (win_port == port_e'(p));
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grant_q <= '0;
      sel_q   <= PORT_N;
      valid_q <= 1'b0;
    end else begin
      grant_q <= grant_d;
      valid_q <= fire;
      // select holds the last winner while idle
      if (fire) begin
        sel_q <= win_port;
      end
    end
  end

  assign fire_o  = fire;
  assign grant_o = grant_q;
  assign sel_o   = sel_q;
  assign valid_o = valid_q;

  a_grant_legal : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0(grant_o) && !grant_o[OUT_PORT]
  ) else $error("port_arbiter: illegal grant vector %b", grant_o);

endmodule : port_arbiter

// ==== design/switch_allocator.sv ====
/*
  switch_allocator
  Switch allocator of a five-port mesh router. One round-robin
  arbiter and one credit counter per output port. Grants and crossbar
  selects appear one cycle after the requests are sampled.
*/
`timescale 1ns/1ps

module switch_allocator #(
  parameter int BUF_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n_i,

  input  logic                          n_req_i,
  input  noc_pkg::port_e                n_dest_i,
  input  logic                          s_req_i,
  input  noc_pkg::port_e                s_dest_i,
  input  logic                          w_req_i,
  input  noc_pkg::port_e                w_dest_i,
  input  logic                          e_req_i,
  input  noc_pkg::port_e                e_dest_i,
  input  logic                          l_req_i,
  input  noc_pkg::port_e                l_dest_i,

  input  logic                          n_credit_ret_i,
  input  logic                          s_credit_ret_i,
  input  logic                          w_credit_ret_i,
  input  logic                          e_credit_ret_i,
  input  logic                          l_credit_ret_i,

  output logic [noc_pkg::NUM_PORTS-1:0] n_grant_o,
  output noc_pkg::port_e                n_sel_o,
  output logic                          n_valid_o,
  output logic [noc_pkg::NUM_PORTS-1:0] s_grant_o,
  output noc_pkg::port_e                s_sel_o,
  output logic                          s_valid_o,
  output logic [noc_pkg::NUM_PORTS-1:0] w_grant_o,
  output noc_pkg::port_e                w_sel_o,
  output logic                          w_valid_o,
  output logic [noc_pkg::NUM_PORTS-1:0] e_grant_o,
  output noc_pkg::port_e                e_sel_o,
  output logic                          e_valid_o,
  output logic [noc_pkg::NUM_PORTS-1:0] l_grant_o,
  output noc_pkg::port_e                l_sel_o,
  output logic                          l_valid_o
);

  import noc_pkg::*;

  logic [NUM_PORTS-1:0] req_vec;
  logic [NUM_PORTS-1:0] credit_ret;
  logic [NUM_PORTS-1:0] credit_ok;
  logic [NUM_PORTS-1:0] grant_fire;
  logic [NUM_PORTS-1:0] grant     [NUM_PORTS];
  port_e                sel       [NUM_PORTS];
  logic [NUM_PORTS-1:0] valid;

  // bit index follows the port code
  assign req_vec    = {l_req_i, e_req_i, w_req_i, s_req_i, n_req_i};
  assign credit_ret = {l_credit_ret_i, e_credit_ret_i, w_credit_ret_i,
                       s_credit_ret_i, n_credit_ret_i};

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
    credit_counter #(
      .BUF_DEPTH (BUF_DEPTH)
    ) u_credit (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .consume_i   (grant_fire[o]),
      .return_i    (credit_ret[o]),
      .credit_ok_o (credit_ok[o])
    );

    port_arbiter #(
      .OUT_PORT (port_e'(o))
    ) u_arb (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .req_i       (req_vec),
      .n_dest_i    (n_dest_i),
      .s_dest_i    (s_dest_i),
      .w_dest_i    (w_dest_i),
      .e_dest_i    (e_dest_i),
      .l_dest_i    (l_dest_i),
      .credit_ok_i (credit_ok[o]),
      .fire_o      (grant_fire[o]),
      .grant_o     (grant[o]),
      .sel_o       (sel[o]),
      .valid_o     (valid[o])
    );
  end

  assign n_grant_o = grant[PORT_N];
  assign n_sel_o   = sel[PORT_N];
  assign n_valid_o = valid[PORT_N];
  assign s_grant_o = grant[PORT_S];
  assign s_sel_o   = sel[PORT_S];
  assign s_valid_o = valid[PORT_S];
  assign w_grant_o = grant[PORT_W];
  assign w_sel_o   = sel[PORT_W];
  assign w_valid_o = valid[PORT_W];
  assign e_grant_o = grant[PORT_E];
  assign e_sel_o   = sel[PORT_E];
  assign e_valid_o = valid[PORT_E];
  assign l_grant_o = grant[PORT_L];
  assign l_sel_o   = sel[PORT_L];
  assign l_valid_o = valid[PORT_L];

endmodule : switch_allocator

// ==== tb/tb_switch_allocator.sv ====
/*
  tb_switch_allocator
  Testbench for the five-port switch allocator. Drives request,
  destination and credit return strobes, predicts every grant with a
  round-robin and credit model and checks all five outputs each cycle.
*/
`timescale 1ns/1ps

module tb_switch_allocator;

  import noc_pkg::*;

  localparam int BUF_DEPTH = 4;
  localparam int WATCHDOG_CYCLES = 20000;

  logic                 clk;
  logic                 rst_n_i;
  logic [NUM_PORTS-1:0] req_q;
  logic [NUM_PORTS-1:0] ret_q;
  port_e                dest_q    [NUM_PORTS];
  logic [NUM_PORTS-1:0] dut_grant [NUM_PORTS];
  port_e                dut_sel   [NUM_PORTS];
  logic [NUM_PORTS-1:0] dut_valid;

  // stimulus staged by the tests, applied on the next edge by step()
  logic [NUM_PORTS-1:0] drv_req;
  logic [NUM_PORTS-1:0] drv_ret;
  port_e                drv_dest  [NUM_PORTS];

  // reference model state and expected outputs
  int                   m_ptr     [NUM_PORTS];
  int                   m_credit  [NUM_PORTS];
  port_e                m_sel     [NUM_PORTS];
  logic [NUM_PORTS-1:0] exp_grant_next [NUM_PORTS];
  logic [NUM_PORTS-1:0] exp_valid_next;
  logic [NUM_PORTS-1:0] exp_grant [NUM_PORTS];
  port_e                exp_sel   [NUM_PORTS];
  logic [NUM_PORTS-1:0] exp_valid;

  port_e                rr_order  [3] = '{PORT_N, PORT_S, PORT_W};
  logic [15:0]          lfsr;
  int                   n_checks;
  int                   n_errors;

  switch_allocator #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .n_req_i        (req_q[PORT_N]),
    .n_dest_i       (dest_q[PORT_N]),
    .s_req_i        (req_q[PORT_S]),
    .s_dest_i       (dest_q[PORT_S]),
    .w_req_i        (req_q[PORT_W]),
    .w_dest_i       (dest_q[PORT_W]),
    .e_req_i        (req_q[PORT_E]),
    .e_dest_i       (dest_q[PORT_E]),
    .l_req_i        (req_q[PORT_L]),
    .l_dest_i       (dest_q[PORT_L]),
    .n_credit_ret_i (ret_q[PORT_N]),
    .s_credit_ret_i (ret_q[PORT_S]),
    .w_credit_ret_i (ret_q[PORT_W]),
    .e_credit_ret_i (ret_q[PORT_E]),
    .l_credit_ret_i (ret_q[PORT_L]),
    .n_grant_o      (dut_grant[PORT_N]),
    .n_sel_o        (dut_sel[PORT_N]),
    .n_valid_o      (dut_valid[PORT_N]),
    .s_grant_o      (dut_grant[PORT_S]),
    .s_sel_o        (dut_sel[PORT_S]),
    .s_valid_o      (dut_valid[PORT_S]),
    .w_grant_o      (dut_grant[PORT_W]),
    .w_sel_o        (dut_sel[PORT_W]),
    .w_valid_o      (dut_valid[PORT_W]),
    .e_grant_o      (dut_grant[PORT_E]),
    .e_sel_o        (dut_sel[PORT_E]),
    .e_valid_o      (dut_valid[PORT_E]),
    .l_grant_o      (dut_grant[PORT_L]),
    .l_sel_o        (dut_sel[PORT_L]),
    .l_valid_o      (dut_valid[PORT_L])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("simulation hung, watchdog expired");
    $display("*** FAILED ***");
    $finish;
  end

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(take_bit());
    end
    return v;
  endfunction

  task automatic check_grant(input logic [NUM_PORTS-1:0] got,
                             input logic [NUM_PORTS-1:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t: %s grant %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(input port_e got, input port_e exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t: %s select %s, expected %s", $time, what, got.name(),
               exp.name());
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t: %s valid %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("[ERROR] %0t: %s was %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // predict the next edge: first desiring candidate from the pointer wins
  task automatic model_step();
    int idx;
    int cand;
    int win;
    logic fire;
    for (int o = 0; o < NUM_PORTS; o++) begin
      win = -1;
      for (int k = CAND_N - 1; k >= 0; k--) begin
        idx = (m_ptr[o] + k) % CAND_N;
        cand = (idx < o) ? idx : idx + 1;
        if (drv_req[cand] && drv_dest[cand] == port_e'(o)) begin
          win = idx;
        end
      end
      fire = (win >= 0) && (m_credit[o] > 0);
      exp_grant_next[o] = '0;
      exp_valid_next[o] = fire;
      if (fire) begin
        cand = (win < o) ? win : win + 1;
        exp_grant_next[o][cand] = 1'b1;
        m_sel[o] = port_e'(cand);
        m_ptr[o] = (win + 1) % CAND_N;
        m_credit[o]--;
      end
      if (drv_ret[o]) begin
        m_credit[o]++;
      end
    end
  endtask

  // one clock: drive staged inputs, then check outputs at the falling edge
  task automatic step();
    port_e op;
    @(posedge clk);
    for (int o = 0; o < NUM_PORTS; o++) begin
      exp_grant[o] = exp_grant_next[o];
      exp_sel[o] = m_sel[o];
      dest_q[o] <= drv_dest[o];
    end
    exp_valid = exp_valid_next;
    req_q <= drv_req;
    ret_q <= drv_ret;
    model_step();
    @(negedge clk);
    for (int o = 0; o < NUM_PORTS; o++) begin
      op = port_e'(o);
      check_grant(dut_grant[o], exp_grant[o], op.name());
      check_sel(dut_sel[o], exp_sel[o], op.name());
      check_valid(dut_valid[o], exp_valid[o], op.name());
    end
  endtask

  task automatic set_idle();
    drv_req = '0;
    drv_ret = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      drv_dest[p] = PORT_N;
    end
  endtask

  task automatic apply_reset();
    set_idle();
    @(posedge clk);
    rst_n_i <= 1'b0;
    req_q <= '0;
    ret_q <= '0;
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    for (int o = 0; o < NUM_PORTS; o++) begin
      m_ptr[o] = 0;
      m_credit[o] = BUF_DEPTH;
      m_sel[o] = PORT_N;
      exp_grant_next[o] = '0;
    end
    exp_valid_next = '0;
  endtask

  task automatic wait_valid(input int o, input int max_cycles, output int cycles);
    cycles = 0;
    while (cycles < max_cycles) begin
      step();
      cycles++;
      if (dut_valid[o]) begin
        break;
      end
    end
    if (!dut_valid[o]) begin
      n_errors++;
      $display("output %0d gave no grant within %0d cycles", o, max_cycles);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s done, %0d errors", num, name, n_errors - errs_before);
  endtask

  initial begin
    int errs;
    int wins;
    int cycles;
    rst_n_i = 1'b0;
    req_q = '0;
    ret_q = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      dest_q[p] = PORT_N;
    end
    lfsr = 16'd17;
    n_checks = 0;
    n_errors = 0;

    errs = n_errors;
    apply_reset();
    repeat (8) begin
      step();
      for (int o = 0; o < NUM_PORTS; o++) begin
        check_valid(dut_valid[o], 1'b0, "idle");
        check_grant(dut_grant[o], '0, "idle");
        check_sel(dut_sel[o], PORT_N, "idle");
      end
    end
    report_test(1, "after reset", errs);

    errs = n_errors;
    apply_reset();
    drv_req[PORT_W] = 1'b1;
    drv_dest[PORT_W] = PORT_N;
    step();
    set_idle();
    wait_valid(PORT_N, 8, cycles);
    check_count(cycles, 1, "grant latency");
    check_grant(dut_grant[PORT_N], 5'b00100, "single request");
    check_sel(dut_sel[PORT_N], PORT_W, "single request");
    step();
    check_valid(dut_valid[PORT_N], 1'b0, "after single grant");
    report_test(2, "single request", errs);

    errs = n_errors;
    apply_reset();
    drv_req = 5'b10111;
    drv_dest[PORT_N] = PORT_L;
    drv_dest[PORT_S] = PORT_L;
    drv_dest[PORT_W] = PORT_L;
    drv_dest[PORT_L] = PORT_L;
    wins = 0;
    for (int i = 0; i < 14; i++) begin
      drv_ret[PORT_L] = (m_credit[PORT_L] < BUF_DEPTH);
      step();
      if (dut_valid[PORT_L]) begin
        check_sel(dut_sel[PORT_L], rr_order[wins % 3], "round robin");
        check_valid(dut_grant[PORT_L][PORT_L], 1'b0, "u-turn");
        wins++;
      end
    end
    check_count(wins, 13, "grants under contention");
    set_idle();
    report_test(3, "round robin", errs);

    errs = n_errors;
    apply_reset();
    drv_req[PORT_N] = 1'b1;
    drv_dest[PORT_N] = PORT_E;
    wins = 0;
    repeat (12) begin
      step();
      wins += int'(dut_valid[PORT_E]);
    end
    check_count(wins, BUF_DEPTH, "grants before exhaustion");
    wins = 0;
    drv_ret[PORT_E] = 1'b1;
    step();
    wins += int'(dut_valid[PORT_E]);
    drv_ret[PORT_E] = 1'b0;
    repeat (8) begin
      step();
      wins += int'(dut_valid[PORT_E]);
    end
    check_count(wins, 1, "grants after one return");
    set_idle();
    report_test(4, "credit exhaustion", errs);

    errs = n_errors;
    apply_reset();
    for (int i = 0; i < 2000; i++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        drv_req[p] = take_bit();
        drv_dest[p] = port_e'(take_bits(3) % NUM_PORTS);
        // a return is only legal while a slot is in use
        drv_ret[p] = take_bit() && (m_credit[p] < BUF_DEPTH);
      end
      step();
    end
    set_idle();
    report_test(5, "random traffic", errs);

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_switch_allocator

// ==== project.f ====
design/noc_pkg.sv
design/rr_priority_ring.sv
design/priority_select.sv
design/credit_counter.sv
design/port_arbiter.sv
design/switch_allocator.sv
tb/tb_switch_allocator.sv

// ==== Makefile ====
# Verilator flow for the switch allocator

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_switch_allocator -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -f project.f --top-module switch_allocator

clean:
	rm -rf obj_dir
